//--- hw/rx_dma_cfg.svh
`ifndef RX_DMA_CFG_SVH
`define RX_DMA_CFG_SVH

// ----------------------------------------------------------
// local memory
// ----------------------------------------------------------
`define MEM_ADDR_BITS   16
`define PKT_RING_MASK   16'h3fff  // 16 KB packet ring
`define DNE_RING_MASK   16'h00ff  // 16 completion slots

// ----------------------------------------------------------
// frame and record sizes
// ----------------------------------------------------------
`define MAX_FRAME_BYTES 1536
`define DNE_BYTES       16

// request fifo depth unless overridden
`define REQ_FIFO_DEPTH  4

`endif

//--- hw/rx_dma_pkg.sv
`default_nettype none
`include "rx_dma_cfg.svh"

package rx_dma_pkg;

   typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;   // local byte address
   typedef logic [63:0]               host_addr_t;  // host byte address
   typedef logic [15:0]               byte_len_t;

   // which requester a queue word came from
   typedef enum logic {
      SRC_PKT = 1'b0,
      SRC_DNE = 1'b1
   } req_src_t;

   typedef struct packed {
      mem_addr_t  local_addr;
      host_addr_t host_addr;
      byte_len_t  len;
   } pkt_req_t;

   // completion copies are always DNE_BYTES long, no length field
   typedef struct packed {
      mem_addr_t  local_addr;
      host_addr_t host_addr;
   } dne_req_t;

   typedef struct packed {
      req_src_t   src;
      byte_len_t  len;
      host_addr_t host_addr;
      mem_addr_t  local_addr;
   } wr_q_word_t;

endpackage

`default_nettype wire

//--- hw/req_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "rx_dma_cfg.svh"

module req_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = `REQ_FIFO_DEPTH
) (
   input  wire logic     clk,
   input  wire logic     rst,
   input  wire logic     push,
   input  wire payload_t push_data,
   input  wire logic     pop,
   output payload_t      head,
   output logic          valid,
   output logic          full
);

   localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_BITS = $clog2(DEPTH + 1);

   payload_t            mem [DEPTH];
   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   logic [CNT_BITS-1:0] count;
   logic                do_push;
   logic                do_pop;

   function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
      if (p == PTR_BITS'(DEPTH - 1)) begin
         return '0;  // wrap for non power of two depths
      end
      return p + 1'b1;
   endfunction

   assign do_push = push & ~full;  // a push into a full fifo is lost
   assign do_pop  = pop & valid;
   assign valid   = (count != '0);
   assign full    = (count == CNT_BITS'(DEPTH));
   assign head    = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/rx_pkt_writer.sv
`timescale 1ns/10ps
`default_nettype none
`include "rx_dma_cfg.svh"

module rx_pkt_writer (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic [63:0]            s_axis_tdata,
   input  wire logic [7:0]             s_axis_tstrb,
   input  wire logic                   s_axis_tvalid,
   input  wire logic                   s_axis_tlast,
   input  wire rx_dma_pkg::byte_len_t  s_axis_tuser_len,
   output logic                        s_axis_tready,
   output logic                        mem_pkt_wr_en,
   output rx_dma_pkg::mem_addr_t       mem_pkt_wr_addr,
   output logic [63:0]                 mem_pkt_wr_data,
   input  wire rx_dma_pkg::host_addr_t host_pkt_offset,
   input  wire rx_dma_pkg::host_addr_t host_pkt_mask,
   input  wire logic                   dne_space,
   output logic                        dne_post,
   output rx_dma_pkg::byte_len_t       dne_pkt_len,
   output rx_dma_pkg::host_addr_t      dne_pkt_host_addr,
   input  wire logic                   pkt_req_pop,
   output logic                        pkt_req_valid,
   output rx_dma_pkg::pkt_req_t        pkt_req
);

   import rx_dma_pkg::*;

   typedef enum logic [1:0] {
      ST_WAIT,
      ST_DATA,
      ST_DROP
   } state_t;

   state_t     state;
   state_t     state_nxt;
   mem_addr_t  pkt_tail;
   mem_addr_t  pkt_tail_nxt;
   mem_addr_t  pkt_start;      // local start of the frame in progress
   mem_addr_t  pkt_start_nxt;
   host_addr_t host_tail;      // held at frame start until the frame ends
   host_addr_t host_tail_nxt;
   byte_len_t  len_reg;
   byte_len_t  len_reg_nxt;
   byte_len_t  rx_bytes;
   byte_len_t  rx_bytes_nxt;
   byte_len_t  rx_bytes_plus_8;
   byte_len_t  cur_len;
   byte_len_t  cur_round;
   mem_addr_t  cur_start;
   byte_len_t  pkt_len;
   logic       pkt_end;
   logic       pkt_full;
   logic       beat;
   pkt_req_t   push_req;

   // bytes in the last beat, counted from the low strobe bit up
   function automatic byte_len_t strb_bytes(input logic [7:0] strb);
      byte_len_t n;
      logic      run;
      n   = '0;
      run = 1'b1;
      for (int i = 0; i < 8; i++) begin
         run = run & strb[i];
         if (run) begin
            n = n + 16'd1;
         end
      end
      return n;
   endfunction

   function automatic byte_len_t round64(input byte_len_t len);
      byte_len_t r;
      r = {len[15:6], 6'b0};
      if (len[5:0] != 6'd0) begin
         r = r + 16'd64;
      end
      return r;
   endfunction

   assign s_axis_tready   = (state != ST_WAIT) | (~pkt_full & dne_space);
   assign beat            = s_axis_tvalid & s_axis_tready;
   assign rx_bytes_plus_8 = rx_bytes + 16'd8;
   assign cur_len         = (state == ST_WAIT) ? s_axis_tuser_len : len_reg;
   assign cur_start       = (state == ST_WAIT) ? pkt_tail : pkt_start;
   assign cur_round       = round64(cur_len);

   assign mem_pkt_wr_addr = pkt_tail;
   assign mem_pkt_wr_data = s_axis_tdata;

   // ----------------------------------------------------------
   // receive fsm
   // ----------------------------------------------------------
   always_comb begin
      state_nxt     = state;
      pkt_tail_nxt  = pkt_tail;
      pkt_start_nxt = pkt_start;
      host_tail_nxt = host_tail;
      len_reg_nxt   = len_reg;
      rx_bytes_nxt  = rx_bytes;
      mem_pkt_wr_en = 1'b0;
      pkt_end       = 1'b0;
      pkt_len       = len_reg;

      case (state)
         ST_WAIT: begin
            if (beat) begin
               if (s_axis_tlast || s_axis_tuser_len > byte_len_t'(`MAX_FRAME_BYTES)) begin
                  if (!s_axis_tlast) begin
                     state_nxt = ST_DROP;
                  end
               end else begin
                  mem_pkt_wr_en = 1'b1;
                  pkt_start_nxt = pkt_tail;
                  len_reg_nxt   = s_axis_tuser_len;
                  rx_bytes_nxt  = 16'd8;
                  pkt_tail_nxt  = (pkt_tail + mem_addr_t'(8)) & `PKT_RING_MASK;
                  if (s_axis_tuser_len <= 16'd8) begin  // length reached on beat one
                     pkt_end   = 1'b1;
                     pkt_len   = s_axis_tuser_len;
                     state_nxt = ST_DROP;
                  end else begin
                     state_nxt = ST_DATA;
                  end
               end
            end
         end
         ST_DATA: begin
            if (beat) begin
               mem_pkt_wr_en = 1'b1;
               pkt_tail_nxt  = (pkt_tail + mem_addr_t'(8)) & `PKT_RING_MASK;
               rx_bytes_nxt  = rx_bytes_plus_8;
               if (s_axis_tlast) begin
                  pkt_end   = 1'b1;
                  pkt_len   = rx_bytes + strb_bytes(s_axis_tstrb);
                  state_nxt = ST_WAIT;
               end else if (rx_bytes_plus_8 >= len_reg) begin
                  pkt_end   = 1'b1;  // rest of the frame is dropped
                  state_nxt = ST_DROP;
               end
            end
         end
         default: begin  // ST_DROP
            if (beat && s_axis_tlast) begin
               state_nxt = ST_WAIT;
            end
         end
      endcase

      // both rings stay 64 byte aligned
      if (pkt_end) begin
         pkt_tail_nxt  = (cur_start + cur_round) & `PKT_RING_MASK;
         host_tail_nxt = (host_tail + host_addr_t'(cur_round)) & host_pkt_mask;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= ST_WAIT;
         pkt_tail  <= '0;
         host_tail <= '0;
      end else begin
         state     <= state_nxt;
         pkt_tail  <= pkt_tail_nxt;
         host_tail <= host_tail_nxt;
      end
      pkt_start <= pkt_start_nxt;
      len_reg   <= len_reg_nxt;
      rx_bytes  <= rx_bytes_nxt;
   end

   // ----------------------------------------------------------
   // packet requests and completion post
   // ----------------------------------------------------------
   assign dne_post          = pkt_end;
   assign dne_pkt_len       = pkt_len;
   assign dne_pkt_host_addr = host_pkt_offset + host_tail;

   assign push_req.local_addr = cur_start;
   assign push_req.host_addr  = dne_pkt_host_addr;
   assign push_req.len        = pkt_len;

   req_fifo #(
      .payload_t (pkt_req_t),
      .DEPTH     (`REQ_FIFO_DEPTH)
   ) u_pkt_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (pkt_end),
      .push_data (push_req),
      .pop       (pkt_req_pop),
      .head      (pkt_req),
      .valid     (pkt_req_valid),
      .full      (pkt_full)
   );

endmodule

`default_nettype wire

//--- hw/rx_dne_writer.sv
`timescale 1ns/10ps
`default_nettype none
`include "rx_dma_cfg.svh"

module rx_dne_writer (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   dne_post,
   input  wire rx_dma_pkg::byte_len_t  dne_pkt_len,
   input  wire rx_dma_pkg::host_addr_t dne_pkt_host_addr,
   input  wire rx_dma_pkg::host_addr_t host_dne_offset,
   input  wire rx_dma_pkg::host_addr_t host_dne_mask,
   output logic                        dne_space,
   output logic                        mem_dne_wr_en,
   output rx_dma_pkg::mem_addr_t       mem_dne_wr_addr,
   output logic [127:0]                mem_dne_wr_data,
   input  wire logic                   dne_req_pop,
   output logic                        dne_req_valid,
   output rx_dma_pkg::dne_req_t        dne_req
);

   import rx_dma_pkg::*;

   logic       post_q;
   byte_len_t  len_q;
   host_addr_t host_q;
   mem_addr_t  dne_tail;
   logic       fifo_full;
   dne_req_t   push_req;

   always_ff @(posedge clk) begin
      if (rst) begin
         post_q    <= 1'b0;
         dne_tail  <= '0;
         dne_space <= 1'b0;
      end else begin
         post_q    <= dne_post;
         // conservative, a post in flight counts as a taken slot
         dne_space <= ~dne_post & ~post_q & ~fifo_full;
         if (post_q) begin
            dne_tail <= (dne_tail + mem_addr_t'(`DNE_BYTES)) & `DNE_RING_MASK;
         end
      end
      if (dne_post) begin
         len_q  <= dne_pkt_len;
         host_q <= dne_pkt_host_addr;
      end
   end

   // record layout: length in [15:0], host packet address in [127:64]
   assign mem_dne_wr_en   = post_q;
   assign mem_dne_wr_addr = dne_tail;
   assign mem_dne_wr_data = {host_q, 48'b0, len_q};

   assign push_req.local_addr = dne_tail;
   assign push_req.host_addr  = (host_dne_offset & ~host_dne_mask) |
                                (host_addr_t'(dne_tail) & host_dne_mask);

   req_fifo #(
      .payload_t (dne_req_t),
      .DEPTH     (`REQ_FIFO_DEPTH)
   ) u_dne_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (post_q),
      .push_data (push_req),
      .pop       (dne_req_pop),
      .head      (dne_req),
      .valid     (dne_req_valid),
      .full      (fifo_full)
   );

endmodule

`default_nettype wire

//--- hw/wr_q_arbiter.sv
`timescale 1ns/10ps
`default_nettype none
`include "rx_dma_cfg.svh"

module wr_q_arbiter (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic                 pkt_req_valid,
   input  wire rx_dma_pkg::pkt_req_t pkt_req,
   input  wire logic                 dne_req_valid,
   input  wire rx_dma_pkg::dne_req_t dne_req,
   output logic                      pkt_req_pop,
   output logic                      dne_req_pop,
   input  wire logic                 wr_q_full,
   output logic                      wr_q_enq_en,
   output rx_dma_pkg::wr_q_word_t    wr_q_enq_data
);

   import rx_dma_pkg::*;

   wr_q_word_t word_nxt;

   // packet copies first, so a completion never overtakes its packet
   assign pkt_req_pop = ~wr_q_full & pkt_req_valid;
   assign dne_req_pop = ~wr_q_full & ~pkt_req_valid & dne_req_valid;

   always_comb begin
      if (pkt_req_valid) begin
         word_nxt.src        = SRC_PKT;
         word_nxt.len        = pkt_req.len;
         word_nxt.host_addr  = pkt_req.host_addr;
         word_nxt.local_addr = pkt_req.local_addr;
      end else begin
         word_nxt.src        = SRC_DNE;
         word_nxt.len        = byte_len_t'(`DNE_BYTES);  // fixed record size
         word_nxt.host_addr  = dne_req.host_addr;
         word_nxt.local_addr = dne_req.local_addr;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_q_enq_en <= 1'b0;
      end else begin
         wr_q_enq_en <= pkt_req_pop | dne_req_pop;
      end
      if (pkt_req_pop || dne_req_pop) begin
         wr_q_enq_data <= word_nxt;
      end
   end

endmodule

`default_nettype wire

//--- hw/rx_dma_top.sv
`timescale 1ns/10ps
`default_nettype none

module rx_dma_top (
   input  wire logic                   clk,
   input  wire logic                   rst,
   // mac stream
   input  wire logic [63:0]            s_axis_tdata,
   input  wire logic [7:0]             s_axis_tstrb,
   input  wire logic                   s_axis_tvalid,
   input  wire logic                   s_axis_tlast,
   input  wire rx_dma_pkg::byte_len_t  s_axis_tuser_len,
   output logic                        s_axis_tready,
   // host ring settings
   input  wire rx_dma_pkg::host_addr_t host_pkt_offset,
   input  wire rx_dma_pkg::host_addr_t host_pkt_mask,
   input  wire rx_dma_pkg::host_addr_t host_dne_offset,
   input  wire rx_dma_pkg::host_addr_t host_dne_mask,
   // local memories
   output logic                        mem_pkt_wr_en,
   output rx_dma_pkg::mem_addr_t       mem_pkt_wr_addr,
   output logic [63:0]                 mem_pkt_wr_data,
   output logic                        mem_dne_wr_en,
   output rx_dma_pkg::mem_addr_t       mem_dne_wr_addr,
   output logic [127:0]                mem_dne_wr_data,
   // pcie write queue
   input  wire logic                   wr_q_full,
   output logic                        wr_q_enq_en,
   output rx_dma_pkg::wr_q_word_t      wr_q_enq_data
);

   import rx_dma_pkg::*;

   // ----------------------------------------------------------
   // internal links
   // ----------------------------------------------------------
   logic       dne_post;
   byte_len_t  dne_pkt_len;
   host_addr_t dne_pkt_host_addr;
   logic       dne_space;
   logic       pkt_req_valid;
   pkt_req_t   pkt_req;
   logic       pkt_req_pop;
   logic       dne_req_valid;
   dne_req_t   dne_req;
   logic       dne_req_pop;

   rx_pkt_writer u_pkt_writer (
      .clk               (clk),
      .rst               (rst),
      .s_axis_tdata      (s_axis_tdata),
      .s_axis_tstrb      (s_axis_tstrb),
      .s_axis_tvalid     (s_axis_tvalid),
      .s_axis_tlast      (s_axis_tlast),
      .s_axis_tuser_len  (s_axis_tuser_len),
      .s_axis_tready     (s_axis_tready),
      .mem_pkt_wr_en     (mem_pkt_wr_en),
      .mem_pkt_wr_addr   (mem_pkt_wr_addr),
      .mem_pkt_wr_data   (mem_pkt_wr_data),
      .host_pkt_offset   (host_pkt_offset),
      .host_pkt_mask     (host_pkt_mask),
      .dne_space         (dne_space),
      .dne_post          (dne_post),
      .dne_pkt_len       (dne_pkt_len),
      .dne_pkt_host_addr (dne_pkt_host_addr),
      .pkt_req_pop       (pkt_req_pop),
      .pkt_req_valid     (pkt_req_valid),
      .pkt_req           (pkt_req)
   );

   rx_dne_writer u_dne_writer (
      .clk               (clk),
      .rst               (rst),
      .dne_post          (dne_post),
      .dne_pkt_len       (dne_pkt_len),
      .dne_pkt_host_addr (dne_pkt_host_addr),
      .host_dne_offset   (host_dne_offset),
      .host_dne_mask     (host_dne_mask),
      .dne_space         (dne_space),
      .mem_dne_wr_en     (mem_dne_wr_en),
      .mem_dne_wr_addr   (mem_dne_wr_addr),
      .mem_dne_wr_data   (mem_dne_wr_data),
      .dne_req_pop       (dne_req_pop),
      .dne_req_valid     (dne_req_valid),
      .dne_req           (dne_req)
   );

   wr_q_arbiter u_arbiter (
      .clk           (clk),
      .rst           (rst),
      .pkt_req_valid (pkt_req_valid),
      .pkt_req       (pkt_req),
      .dne_req_valid (dne_req_valid),
      .dne_req       (dne_req),
      .pkt_req_pop   (pkt_req_pop),
      .dne_req_pop   (dne_req_pop),
      .wr_q_full     (wr_q_full),
      .wr_q_enq_en   (wr_q_enq_en),
      .wr_q_enq_data (wr_q_enq_data)
   );

endmodule

`default_nettype wire

//--- test/rx_dma_checker.sv
`timescale 1ns/10ps
`default_nettype none

module rx_dma_checker (
   input wire logic clk,
   input wire logic rst,
   input wire logic s_axis_tvalid,
   input wire logic s_axis_tready,
   input wire logic mem_pkt_wr_en,
   input wire logic wr_q_full,
   input wire logic wr_q_enq_en
);

   int fail_count = 0;  // failed assertions so far

   // stream held off once reset has been seen on an edge
   a_ready_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> !s_axis_tready)
      else begin
         fail_count++;
         $error("s_axis_tready high during reset");
      end

   // a queue word needs a pop, and a pop needs wr_q_full low
   a_enq_after_space: assert property (@(posedge clk) disable iff (rst)
      wr_q_enq_en |-> !$past(wr_q_full))
      else begin
         fail_count++;
         $error("wr_q_enq_en high one cycle after wr_q_full was high");
      end

   a_write_on_beat: assert property (@(posedge clk) disable iff (rst)
      mem_pkt_wr_en |-> (s_axis_tvalid && s_axis_tready))
      else begin
         fail_count++;
         $error("packet memory write without a stream handshake");
      end

endmodule

`default_nettype wire

//--- test/rx_dma_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "rx_dma_cfg.svh"

module rx_dma_tb;

   import rx_dma_pkg::*;

   localparam int N_FRAMES     = 12;
   localparam int DRAIN_CYCLES = 400;

   // frame table with one column per frame
   // tuser length, beat count, last-beat strobe, queue stall while streaming,
   // expected packet length or zero for a dropped frame
   localparam int T_LEN   [N_FRAMES] = '{64, 13, 100, 2000, 8, 40, 72, 30, 200, 1536, 5, 64};
   localparam int T_BEATS [N_FRAMES] = '{8, 2, 13, 4, 1, 8, 9, 4, 25, 192, 3, 8};
   localparam int T_STRB  [N_FRAMES] = '{'hff, 'h1f, 'h0f, 'hff, 'hff, 'hff,
                                         'hff, 'h3f, 'hff, 'hff, 'hff, 'hff};
   localparam int T_STALL [N_FRAMES] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 0, 0};
   localparam int T_PLEN  [N_FRAMES] = '{64, 13, 100, 0, 0, 40, 72, 30, 200, 1536, 5, 64};

   localparam host_addr_t HOST_PKT_OFFSET = 64'h0000_0001_0000_0000;
   localparam host_addr_t HOST_PKT_MASK   = 64'h0000_0000_0000_07ff;  // 2 KB host ring
   localparam host_addr_t HOST_DNE_OFFSET = 64'h0000_0002_0000_1fc3;
   localparam host_addr_t HOST_DNE_MASK   = 64'h0000_0000_0000_00ff;

   typedef struct packed {
      int           frame;
      mem_addr_t    addr;
      logic [127:0] data;
      wr_q_word_t   word;
   } expect_t;

   logic         clk = 1'b0;
   logic         rst;
   logic [63:0]  s_axis_tdata;
   logic [7:0]   s_axis_tstrb;
   logic         s_axis_tvalid;
   logic         s_axis_tlast;
   byte_len_t    s_axis_tuser_len;
   logic         s_axis_tready;
   host_addr_t   host_pkt_offset;
   host_addr_t   host_pkt_mask;
   host_addr_t   host_dne_offset;
   host_addr_t   host_dne_mask;
   logic         mem_pkt_wr_en;
   mem_addr_t    mem_pkt_wr_addr;
   logic [63:0]  mem_pkt_wr_data;
   logic         mem_dne_wr_en;
   mem_addr_t    mem_dne_wr_addr;
   logic [127:0] mem_dne_wr_data;
   logic         wr_q_full;
   logic         wr_q_enq_en;
   wr_q_word_t   wr_q_enq_data;

   int           seed = 32'hc428_2b27;
   logic [63:0]  beat_data [256];
   expect_t      exp_mem_q [$];
   expect_t      exp_rec_q [$];
   expect_t      exp_pkt_q [$];
   expect_t      exp_dne_q [$];
   logic         kept [N_FRAMES];
   logic         pkt_seen [N_FRAMES];
   logic         frame_done [N_FRAMES];
   int           frame_errs [N_FRAMES];
   int           err_count = 0;
   int           cur_frame = 0;
   logic         full_last = 1'b0;
   mem_addr_t    m_pkt_tail;   // model tails
   host_addr_t   m_host_tail;
   mem_addr_t    m_dne_tail;

   always #5 clk = ~clk;

   rx_dma_top u_dut (
      .clk              (clk),
      .rst              (rst),
      .s_axis_tdata     (s_axis_tdata),
      .s_axis_tstrb     (s_axis_tstrb),
      .s_axis_tvalid    (s_axis_tvalid),
      .s_axis_tlast     (s_axis_tlast),
      .s_axis_tuser_len (s_axis_tuser_len),
      .s_axis_tready    (s_axis_tready),
      .host_pkt_offset  (host_pkt_offset),
      .host_pkt_mask    (host_pkt_mask),
      .host_dne_offset  (host_dne_offset),
      .host_dne_mask    (host_dne_mask),
      .mem_pkt_wr_en    (mem_pkt_wr_en),
      .mem_pkt_wr_addr  (mem_pkt_wr_addr),
      .mem_pkt_wr_data  (mem_pkt_wr_data),
      .mem_dne_wr_en    (mem_dne_wr_en),
      .mem_dne_wr_addr  (mem_dne_wr_addr),
      .mem_dne_wr_data  (mem_dne_wr_data),
      .wr_q_full        (wr_q_full),
      .wr_q_enq_en      (wr_q_enq_en),
      .wr_q_enq_data    (wr_q_enq_data)
   );

   bind rx_dma_top rx_dma_checker u_checker (
      .clk           (clk),
      .rst           (rst),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .mem_pkt_wr_en (mem_pkt_wr_en),
      .wr_q_full     (wr_q_full),
      .wr_q_enq_en   (wr_q_enq_en)
   );

   // ----------------------------------------------------------
   // reference model
   // ----------------------------------------------------------
   function automatic int round_up64(input int len);
      return ((len + 63) / 64) * 64;
   endfunction

   task automatic plan_frame(input int idx);
      int         len;
      int         n;
      int         need;
      int         wr_beats;
      int         plen;
      host_addr_t host_pkt;
      host_addr_t host_dne;
      host_addr_t dne_tail_wide;
      expect_t    e;
      len  = T_LEN[idx];
      n    = T_BEATS[idx];
      plen = T_PLEN[idx];
      for (int b = 0; b < n; b++) begin
         beat_data[b] = {$random(seed), $random(seed)};
      end
      kept[idx] = (plen != 0);
      if (!kept[idx]) begin
         return;  // dropped frames leave every tail alone
      end
      need     = (len + 7) / 8;
      wr_beats = (need < n) ? need : n;  // tuser length may be reached before tlast
      host_pkt = HOST_PKT_OFFSET + m_host_tail;
      e        = '0;
      e.frame  = idx;
      for (int b = 0; b < wr_beats; b++) begin
         e.addr = (m_pkt_tail + mem_addr_t'(8 * b)) & `PKT_RING_MASK;
         e.data = 128'(beat_data[b]);
         exp_mem_q.push_back(e);
      end
      e.word.src        = SRC_PKT;
      e.word.len        = byte_len_t'(plen);
      e.word.host_addr  = host_pkt;
      e.word.local_addr = m_pkt_tail;
      exp_pkt_q.push_back(e);
      e.addr           = m_dne_tail;
      e.data           = '0;
      e.data[15:0]     = byte_len_t'(plen);
      e.data[127:64]   = host_pkt;
      exp_rec_q.push_back(e);
      // offset bits under the mask come from the completion tail
      dne_tail_wide = host_addr_t'(m_dne_tail);
      host_dne      = HOST_DNE_OFFSET;
      for (int k = 0; k < 64; k++) begin
         if (HOST_DNE_MASK[k]) begin
            host_dne[k] = dne_tail_wide[k];
         end
      end
      e.word.src        = SRC_DNE;
      e.word.len        = byte_len_t'(`DNE_BYTES);
      e.word.host_addr  = host_dne;
      e.word.local_addr = m_dne_tail;
      exp_dne_q.push_back(e);
      m_pkt_tail  = (m_pkt_tail + mem_addr_t'(round_up64(len))) & `PKT_RING_MASK;
      m_host_tail = (m_host_tail + host_addr_t'(round_up64(len))) & HOST_PKT_MASK;
      m_dne_tail  = (m_dne_tail + mem_addr_t'(`DNE_BYTES)) & `DNE_RING_MASK;
   endtask

   // ----------------------------------------------------------
   // stream driver
   // ----------------------------------------------------------
   task automatic send_frame(input int idx);
      logic took;
      wr_q_full = (T_STALL[idx] != 0);
      for (int b = 0; b < T_BEATS[idx]; b++) begin
         s_axis_tvalid    = 1'b1;
         s_axis_tdata     = beat_data[b];
         s_axis_tlast     = (b == T_BEATS[idx] - 1);
         s_axis_tstrb     = s_axis_tlast ? 8'(T_STRB[idx]) : 8'hff;
         s_axis_tuser_len = byte_len_t'(T_LEN[idx]);
         took = 1'b0;
         while (!took) begin
            @(negedge clk);
            took = s_axis_tready;  // beat moves on the coming edge
            @(posedge clk);
            #1;
         end
      end
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
   endtask

   task automatic count_error(input int frame);
      err_count++;
      if (frame >= 0 && frame < N_FRAMES) begin
         frame_errs[frame]++;
      end
   endtask

   task automatic report_failure(input int frame, input string msg);
      $display("%0s", msg);
      count_error(frame);
   endtask

   task automatic check_field(input int frame, input string name,
                              input logic [127:0] got, input logic [127:0] exp);
      if (got !== exp) begin
         $display("mismatch %0s: got %0h, expected %0h (frame %0d)", name, got, exp, frame);
         count_error(frame);
      end
   endtask

   task automatic check_word(input expect_t e);
      check_field(e.frame, "wr_q_enq_data.src", 128'(wr_q_enq_data.src), 128'(e.word.src));
      check_field(e.frame, "wr_q_enq_data.len", 128'(wr_q_enq_data.len), 128'(e.word.len));
      check_field(e.frame, "wr_q_enq_data.host_addr", 128'(wr_q_enq_data.host_addr),
                  128'(e.word.host_addr));
      check_field(e.frame, "wr_q_enq_data.local_addr", 128'(wr_q_enq_data.local_addr),
                  128'(e.word.local_addr));
   endtask

   // ----------------------------------------------------------
   // output monitor sampled mid cycle
   // ----------------------------------------------------------
   always @(negedge clk) begin : monitor
      expect_t e;
      if (!rst) begin
         if (wr_q_enq_en && full_last) begin
            report_failure(cur_frame, "queue word enqueued the cycle after wr_q_full was high");
         end
         if (mem_pkt_wr_en) begin
            if (exp_mem_q.size() == 0) begin
               report_failure(cur_frame, $sformatf("unexpected packet memory write at %0h",
                                                   mem_pkt_wr_addr));
            end else begin
               e = exp_mem_q.pop_front();
               check_field(e.frame, "mem_pkt_wr_addr", 128'(mem_pkt_wr_addr), 128'(e.addr));
               check_field(e.frame, "mem_pkt_wr_data", 128'(mem_pkt_wr_data), e.data);
            end
         end
         if (mem_dne_wr_en) begin
            if (exp_rec_q.size() == 0) begin
               report_failure(cur_frame, "unexpected completion memory write");
            end else begin
               e = exp_rec_q.pop_front();
               check_field(e.frame, "mem_dne_wr_addr", 128'(mem_dne_wr_addr), 128'(e.addr));
               check_field(e.frame, "mem_dne_wr_data", mem_dne_wr_data, e.data);
            end
         end
         if (wr_q_enq_en && wr_q_enq_data.src == SRC_PKT) begin
            if (exp_pkt_q.size() == 0) begin
               report_failure(cur_frame, "packet word enqueued that no frame should produce");
            end else begin
               e = exp_pkt_q.pop_front();
               check_word(e);
               pkt_seen[e.frame] = 1'b1;
            end
         end else if (wr_q_enq_en) begin
            if (exp_dne_q.size() == 0) begin
               report_failure(cur_frame, "completion word enqueued that no frame should produce");
            end else begin
               e = exp_dne_q.pop_front();
               check_word(e);
               if (!pkt_seen[e.frame]) begin
                  report_failure(e.frame, $sformatf("frame %0d completion came before its packet",
                                                    e.frame));
               end
               frame_done[e.frame] = 1'b1;
               $display("frame %0d: len %0d, %0d beats, %0s", e.frame, T_LEN[e.frame],
                        T_BEATS[e.frame], (frame_errs[e.frame] == 0) ? "ok" : "failed");
            end
         end
      end
      full_last = wr_q_full;
   end

   // ----------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------
   initial begin : main
      int cycles;
      int passed;
      rst              = 1'b1;
      s_axis_tdata     = '0;
      s_axis_tstrb     = '0;
      s_axis_tvalid    = 1'b0;
      s_axis_tlast     = 1'b0;
      s_axis_tuser_len = '0;
      host_pkt_offset  = HOST_PKT_OFFSET;
      host_pkt_mask    = HOST_PKT_MASK;
      host_dne_offset  = HOST_DNE_OFFSET;
      host_dne_mask    = HOST_DNE_MASK;
      wr_q_full        = 1'b0;
      m_pkt_tail       = '0;
      m_host_tail      = '0;
      m_dne_tail       = '0;
      for (int i = 0; i < N_FRAMES; i++) begin
         kept[i]       = 1'b0;
         pkt_seen[i]   = 1'b0;
         frame_done[i] = 1'b0;
         frame_errs[i] = 0;
      end
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      for (int i = 0; i < N_FRAMES; i++) begin
         cur_frame = i;
         plan_frame(i);
         send_frame(i);
         if (!kept[i]) begin
            repeat (4) @(posedge clk);  // give stray writes time to show
            #1;
            $display("frame %0d: len %0d, %0d beats, dropped, %0s", i, T_LEN[i], T_BEATS[i],
                     (frame_errs[i] == 0) ? "ok" : "failed");
         end
      end

      wr_q_full = 1'b0;
      cycles    = 0;
      while ((exp_mem_q.size() + exp_rec_q.size() + exp_pkt_q.size() + exp_dne_q.size()) != 0
             && cycles < DRAIN_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      repeat (8) @(posedge clk);
      if (exp_mem_q.size() != 0) begin
         report_failure(-1, $sformatf("%0d packet memory writes never happened",
                                      exp_mem_q.size()));
      end
      if (exp_rec_q.size() != 0) begin
         report_failure(-1, $sformatf("%0d completion memory writes never happened",
                                      exp_rec_q.size()));
      end
      if (exp_pkt_q.size() != 0) begin
         report_failure(-1, $sformatf("%0d packet words never arrived", exp_pkt_q.size()));
      end
      if (exp_dne_q.size() != 0) begin
         report_failure(-1, $sformatf("%0d completion words never arrived", exp_dne_q.size()));
      end
      if (u_dut.u_checker.fail_count != 0) begin
         report_failure(-1, $sformatf("%0d assertions failed in the bound checker",
                                      u_dut.u_checker.fail_count));
      end

      passed = 0;
      for (int i = 0; i < N_FRAMES; i++) begin
         if (kept[i] && !frame_done[i]) begin
            report_failure(i, $sformatf("frame %0d never finished", i));
         end else if (frame_errs[i] == 0) begin
            passed++;
         end
      end
      $display("frames %0d, passed %0d, failed %0d, errors %0d", N_FRAMES, passed,
               N_FRAMES - passed, err_count);
      if (err_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // bound by the table length with stalls included
   initial begin : watchdog
      int limit;
      limit = 0;
      for (int i = 0; i < N_FRAMES; i++) begin
         limit += T_BEATS[i];
      end
      limit = limit * 20 + DRAIN_CYCLES + 200;
      repeat (limit) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/rx_dma_pkg.sv
hw/req_fifo.sv
hw/rx_pkt_writer.sv
hw/rx_dne_writer.sv
hw/wr_q_arbiter.sv
hw/rx_dma_top.sv
test/rx_dma_checker.sv
test/rx_dma_tb.sv

//--- Bender.yml
package:
  name: rx_dma

sources:
  - include_dirs:
      - hw
    files:
      - hw/rx_dma_pkg.sv
      - hw/req_fifo.sv
      - hw/rx_pkt_writer.sv
      - hw/rx_dne_writer.sv
      - hw/wr_q_arbiter.sv
      - hw/rx_dma_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/rx_dma_checker.sv
      - test/rx_dma_tb.sv
